//--- design/avr_pkg.sv
// shared types and constants for the 8-bit AVR-style core
// every design module pulls this in with a wildcard import
// in its module header

`default_nettype none

package avr_pkg;

  ////////////////////////////////////////
  // data widths
  ////////////////////////////////////////

  typedef logic [7:0]  byte_t;     // register / i/o data
  typedef logic [15:0] word_t;     // program memory word
  typedef logic [4:0]  reg_addr_t; // r0 .. r31
  typedef logic [5:0]  io_addr_t;  // 64 i/o locations
  typedef logic [7:0]  sreg_t;     // status byte

  // status bit positions, avr order
  localparam int unsigned SREG_I = 7; // global irq enable, no irqs here
  localparam int unsigned SREG_T = 6; // bit copy storage
  localparam int unsigned SREG_H = 5; // half carry
  localparam int unsigned SREG_S = 4; // sign, n ^ v
  localparam int unsigned SREG_V = 3; // two's complement overflow
  localparam int unsigned SREG_N = 2; // negative
  localparam int unsigned SREG_Z = 1; // zero
  localparam int unsigned SREG_C = 0; // carry / borrow

  ////////////////////////////////////////
  // i/o map
  ////////////////////////////////////////

  localparam io_addr_t IOA_SREG          = 6'h3f; // status register
  localparam io_addr_t IOA_INTERNAL_BASE = 6'h38; // 0x38 and up stay inside the core

  // alu operation select
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0, // a + b + cin
    ALU_SUB = 3'd1, // a - b - cin
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_EOR = 3'd4,
    ALU_SHR = 3'd5  // shift right, cin enters at bit 7
  } alu_op_t;

endpackage

`default_nettype wire

//--- design/avr_fetch.sv
// instruction fetch for the 8-bit core
// holds the program counter and drives the program bus request;
// each word returned with bp_rdy high is handed to decode as one instruction

`timescale 1ns/1ps
`default_nettype none

module avr_fetch import avr_pkg::*; #(
  parameter int unsigned PAW = 11 // program address width, words
) (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              bp_rdy,   // memory word valid
  input  wire logic              jump_en,  // taken rjmp
  input  wire logic signed [11:0] jump_off, // rjmp displacement
  input  wire word_t             bp_rdt,
  output logic                   bp_vld,
  output logic [PAW-1:0]         bp_adr,
  output word_t                  inst_word,
  output logic                   inst_vld
);

  logic [PAW-1:0] pc;       // address of the word now on bp_rdt
  logic [PAW-1:0] jump_ext; // displacement sized to the pc
  logic           rst_dly;  // high through reset and one cycle after

  always_ff @(posedge clk, posedge rst) begin
    if (rst) rst_dly <= 1'b1;
    else     rst_dly <= 1'b0;
  end

  assign bp_vld = ~rst_dly;

  // sign extends or wraps depending on PAW
  assign jump_ext = PAW'(jump_off);

  // next request: re-request, step or relative jump
  always_comb begin
    if (!inst_vld)    bp_adr = pc; // stalled, ask again
    else if (jump_en) bp_adr = pc + PAW'(1) + jump_ext;
    else              bp_adr = pc + PAW'(1);
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst)           pc <= '0;
    else if (inst_vld) pc <= bp_adr; // follows the word just requested
  end

  assign inst_word = bp_rdt;
  assign inst_vld  = bp_rdy;

endmodule

`default_nettype wire

//--- design/avr_decode.sv
// combinational instruction decoder
// turns the qualified program word into register file, alu, status,
// i/o, jump and control commands; unknown words fall through as nop

`timescale 1ns/1ps
`default_nettype none

module avr_decode import avr_pkg::*; #(
  parameter int unsigned PAW = 11
) (
  input  wire word_t     inst_word,
  input  wire logic      inst_vld,
  input  wire byte_t     rd_data,
  input  wire byte_t     rr_data,
  input  wire byte_t     alu_res,
  input  wire sreg_t     alu_flags,
  input  wire byte_t     io_data,
  input  wire sreg_t     sreg,
  output reg_addr_t      rd_addr,
  output reg_addr_t      rr_addr,
  output reg_addr_t      wr_addr,
  output logic           wr_en,
  output byte_t          wr_data,
  output alu_op_t        alu_op,
  output byte_t          alu_a,
  output byte_t          alu_b,
  output logic           alu_cin,
  output sreg_t          flag_mask,
  output sreg_t          flag_val,
  output logic           io_wr,
  output logic           io_rd,
  output io_addr_t       io_addr,
  output byte_t          io_wdata,
  output logic           jump_en,
  output logic signed [11:0] jump_off,
  output logic           ctl_slp,
  output logic           ctl_brk,
  output logic           ctl_wdr
);

  // flag groups
  localparam sreg_t M_SVNZ = (8'd1 << SREG_S) | (8'd1 << SREG_V) |
                             (8'd1 << SREG_N) | (8'd1 << SREG_Z);
  localparam sreg_t M_SVNZC  = M_SVNZ | (8'd1 << SREG_C);
  localparam sreg_t M_HSVNZC = M_SVNZC | (8'd1 << SREG_H);

  // relative jump arithmetic is only checked for these widths
  if (PAW < 8 || PAW > 16) begin : g_paw_range
    $error("avr_decode: PAW must be within 8 to 16");
  end

  reg_addr_t f_d;  // full range destination
  reg_addr_t f_r;  // full range source
  reg_addr_t f_h;  // r16..r31, immediate forms
  byte_t     f_k;  // byte immediate
  logic      z_keep;

  assign f_d = inst_word[8:4];
  assign f_r = {inst_word[9], inst_word[3:0]};
  assign f_h = {1'b1, inst_word[7:4]};
  assign f_k = {inst_word[11:8], inst_word[3:0]};

  // with-carry subtracts only clear z, never set it
  assign z_keep = alu_flags[SREG_Z] & sreg[SREG_Z];

  always_comb begin
    rd_addr   = f_d;
    rr_addr   = f_r;
    wr_addr   = f_d;
    wr_en     = 1'b0;
    wr_data   = alu_res;
    alu_op    = ALU_ADD;
    alu_a     = rd_data;
    alu_b     = rr_data;
    alu_cin   = 1'b0;
    flag_mask = '0;
    flag_val  = alu_flags;
    io_wr     = 1'b0;
    io_rd     = 1'b0;
    io_addr   = {inst_word[10:9], inst_word[3:0]};
    io_wdata  = rd_data;
    jump_en   = 1'b0;
    jump_off  = inst_word[11:0];
    ctl_slp   = 1'b0;
    ctl_brk   = 1'b0;
    ctl_wdr   = 1'b0;
    if (inst_vld) begin
      casez (inst_word)
        16'b1001_0101_1000_1000: ctl_slp = 1'b1; // SLEEP
        16'b1001_0101_1001_1000: ctl_brk = 1'b1; // BREAK
        16'b1001_0101_1010_1000: ctl_wdr = 1'b1; // WDR
        16'b000?_11??_????_????: begin // ADD, ADC when bit 12 set
          wr_en     = 1'b1;
          alu_cin   = inst_word[12] & sreg[SREG_C];
          flag_mask = M_HSVNZC;
        end
        16'b000?_10??_????_????,
        16'b000?_01??_????_????: begin // SUB/SBC, CP/CPC
          wr_en     = inst_word[11];
          alu_op    = ALU_SUB;
          alu_cin   = ~inst_word[12] & sreg[SREG_C];
          flag_mask = M_HSVNZC;
          if (!inst_word[12]) flag_val[SREG_Z] = z_keep;
        end
        16'b0011_????_????_????,
        16'b010?_????_????_????: begin // CPI, SBCI, SUBI
          rd_addr   = f_h;
          wr_addr   = f_h;
          wr_en     = inst_word[14]; // cpi writes nothing
          alu_op    = ALU_SUB;
          alu_b     = f_k;
          alu_cin   = inst_word[14] & ~inst_word[12] & sreg[SREG_C];
          flag_mask = M_HSVNZC;
          if (inst_word[14] && !inst_word[12]) flag_val[SREG_Z] = z_keep;
        end
        16'b0010_00??_????_????: begin // AND
          wr_en     = 1'b1;
          alu_op    = ALU_AND;
          flag_mask = M_SVNZ;
        end
        16'b0010_01??_????_????: begin // EOR
          wr_en     = 1'b1;
          alu_op    = ALU_EOR;
          flag_mask = M_SVNZ;
        end
        16'b0010_10??_????_????: begin // OR
          wr_en     = 1'b1;
          alu_op    = ALU_OR;
          flag_mask = M_SVNZ;
        end
        16'b0010_11??_????_????: begin // MOV
          wr_en   = 1'b1;
          wr_data = rr_data;
        end
        16'b011?_????_????_????: begin // ORI, ANDI
          rd_addr   = f_h;
          wr_addr   = f_h;
          wr_en     = 1'b1;
          alu_op    = inst_word[12] ? ALU_AND : ALU_OR;
          alu_b     = f_k;
          flag_mask = M_SVNZ;
        end
        16'b1110_????_????_????: begin // LDI
          wr_addr = f_h;
          wr_en   = 1'b1;
          wr_data = f_k;
        end
        16'b1001_0100_????_1000: begin // BSET, BCLR on bit 7
          flag_mask = sreg_t'(8'd1 << inst_word[6:4]);
          flag_val  = {8{~inst_word[7]}};
        end
        16'b1001_010?_????_0???,
        16'b1001_010?_????_1010: begin // one operand group
          wr_en     = 1'b1;
          flag_mask = M_SVNZC;
          case (inst_word[3:0])
            4'h0: begin // COM, c always set
              alu_op             = ALU_EOR;
              alu_b              = 8'hff;
              flag_val[SREG_C]   = 1'b1;
            end
            4'h1: begin // NEG = 0 - rd
              alu_op = ALU_SUB;
              alu_a  = 8'h00;
              alu_b  = rd_data;
            end
            4'h2: begin // SWAP, no flags
              wr_data   = {rd_data[3:0], rd_data[7:4]};
              flag_mask = '0;
            end
            4'h3: begin // INC keeps c
              alu_b     = 8'h00;
              alu_cin   = 1'b1;
              flag_mask = M_SVNZ;
            end
            4'h5: begin // ASR
              alu_op  = ALU_SHR;
              alu_cin = rd_data[7];
            end
            4'h6: alu_op = ALU_SHR; // LSR
            4'h7: begin // ROR through carry
              alu_op  = ALU_SHR;
              alu_cin = sreg[SREG_C];
            end
            4'ha: begin // DEC keeps c
              alu_op    = ALU_SUB;
              alu_b     = 8'h00;
              alu_cin   = 1'b1;
              flag_mask = M_SVNZ;
            end
            default: begin // reserved slot
              wr_en     = 1'b0;
              flag_mask = '0;
            end
          endcase
        end
        16'b1011_0???_????_????: begin // IN
          io_rd   = 1'b1;
          wr_en   = 1'b1;
          wr_data = io_data;
        end
        16'b1011_1???_????_????: io_wr = 1'b1;   // OUT rd
        16'b1100_????_????_????: jump_en = 1'b1; // RJMP
        default: ; // nop and unsupported words
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/avr_regfile.sv
// general purpose registers r0..r31
// two combinational read ports for the operands, one write port
// that commits at the rising edge

`timescale 1ns/1ps
`default_nettype none

module avr_regfile import avr_pkg::*; (
  input  wire logic      clk,
  input  wire reg_addr_t rd_addr, // destination operand read
  input  wire reg_addr_t rr_addr, // source operand read
  input  wire logic      wr_en,
  input  wire reg_addr_t wr_addr,
  input  wire byte_t     wr_data,
  output byte_t          rd_data,
  output byte_t          rr_data
);

  byte_t regs [32]; // contents undefined after reset

  always_ff @(posedge clk) begin
    if (wr_en) regs[wr_addr] <= wr_data;
  end

  // reads see the old value in the cycle of a write
  assign rd_data = regs[rd_addr];
  assign rr_data = regs[rr_addr];

endmodule

`default_nettype wire

//--- design/avr_alu.sv
// byte alu
// add and subtract with carry in, and/or/eor, right shift with a
// supplied top bit; returns the result and every candidate flag,
// decode picks which flags actually land in the status register

`timescale 1ns/1ps
`default_nettype none

module avr_alu import avr_pkg::*; (
  input  wire alu_op_t alu_op,
  input  wire byte_t   alu_a,
  input  wire byte_t   alu_b,
  input  wire logic    alu_cin, // carry, borrow or shift-in bit
  output byte_t        alu_res,
  output sreg_t        alu_flags
);

  logic [8:0] sum; // result with carry / borrow on top
  logic       half;
  logic       ovf;

  always_comb begin
    case (alu_op)
      ALU_ADD: sum = {1'b0, alu_a} + {1'b0, alu_b} + 9'(alu_cin);
      ALU_SUB: sum = {1'b0, alu_a} - {1'b0, alu_b} - 9'(alu_cin);
      ALU_AND: sum = {1'b0, alu_a & alu_b};
      ALU_OR:  sum = {1'b0, alu_a | alu_b};
      ALU_EOR: sum = {1'b0, alu_a ^ alu_b};
      ALU_SHR: sum = {alu_a[0], alu_cin, alu_a[7:1]}; // bit 0 falls into carry
      default: sum = '0;
    endcase
  end

  assign alu_res = sum[7:0];

  // half carry and overflow follow the avr equations
  always_comb begin
    half = 1'b0;
    ovf  = 1'b0;
    case (alu_op)
      ALU_ADD: begin
        half = alu_a[3] & alu_b[3] | alu_b[3] & ~alu_res[3] | ~alu_res[3] & alu_a[3];
        ovf  = alu_a[7] & alu_b[7] & ~alu_res[7] | ~alu_a[7] & ~alu_b[7] & alu_res[7];
      end
      ALU_SUB: begin
        half = ~alu_a[3] & alu_b[3] | alu_b[3] & alu_res[3] | alu_res[3] & ~alu_a[3];
        ovf  = alu_a[7] & ~alu_b[7] & ~alu_res[7] | ~alu_a[7] & alu_b[7] & alu_res[7];
      end
      ALU_SHR: ovf = alu_res[7] ^ sum[8]; // n ^ c
      default: ; // logic ops clear v
    endcase
  end

  always_comb begin
    alu_flags         = '0;
    alu_flags[SREG_I] = 1'b0; // never produced here
    alu_flags[SREG_T] = 1'b0;
    alu_flags[SREG_H] = half;
    alu_flags[SREG_V] = ovf;
    alu_flags[SREG_N] = alu_res[7];
    alu_flags[SREG_S] = alu_res[7] ^ ovf;
    alu_flags[SREG_Z] = ~|alu_res;
    alu_flags[SREG_C] = sum[8];
  end

endmodule

`default_nettype wire

//--- design/avr_sreg_io.sv
// status register and i/o port
// sreg takes masked flag updates or a full load from OUT 0x3f;
// addresses 0x38..0x3f are kept off the external i/o bus

`timescale 1ns/1ps
`default_nettype none

module avr_sreg_io import avr_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire sreg_t    flag_mask, // bits to update
  input  wire sreg_t    flag_val,
  input  wire logic     io_wr,     // OUT
  input  wire logic     io_rd,     // IN
  input  wire io_addr_t io_addr,
  input  wire byte_t    io_wdata,
  input  wire byte_t    io_rdt,    // external read data
  output sreg_t         sreg,
  output byte_t         io_data,   // value returned to IN
  output logic          io_wen,
  output logic          io_ren,
  output io_addr_t      io_adr,
  output byte_t         io_wdt,
  output byte_t         io_msk
);

  logic internal; // address never leaves the core
  logic sreg_ld;  // OUT to the status register

  assign internal = (io_addr >= IOA_INTERNAL_BASE);
  assign sreg_ld  = io_wr & (io_addr == IOA_SREG);

  always_ff @(posedge clk, posedge rst) begin
    if (rst)                sreg <= '0;
    else if (sreg_ld)       sreg <= io_wdata;
    else if (|flag_mask)    sreg <= (flag_val & flag_mask) | (sreg & ~flag_mask);
  end

  // IN source
  assign io_data = (io_addr == IOA_SREG) ? sreg : io_rdt;

  ////////////////////////////////////////
  // external bus
  ////////////////////////////////////////

  assign io_wen = io_wr & ~internal;
  assign io_ren = io_rd & ~internal;
  assign io_adr = io_addr;
  assign io_wdt = io_wdata;
  assign io_msk = io_wen ? 8'hff : 8'h00; // whole byte writes only

endmodule

`default_nettype wire

//--- design/avr_core.sv
// top of the 8-bit AVR-style core
// one instruction per valid program word, no pipeline delay:
// the word on bp_rdt commits at the next rising edge while its
// i/o strobes and control pulses show in the same cycle

`timescale 1ns/1ps
`default_nettype none

module avr_core import avr_pkg::*; #(
  parameter int unsigned PAW = 11 // program address width, words
) (
  input  wire logic      clk,
  input  wire logic      rst,
  // program bus
  output logic           bp_vld,
  output logic [PAW-1:0] bp_adr,
  input  wire word_t     bp_rdt,
  input  wire logic      bp_rdy,
  // i/o peripheral bus
  output logic           io_wen,
  output logic           io_ren,
  output io_addr_t       io_adr,
  output byte_t          io_wdt,
  output byte_t          io_msk,
  input  wire byte_t     io_rdt,
  // control pulses
  output logic           ctl_slp,
  output logic           ctl_brk,
  output logic           ctl_wdr
);

  word_t              inst_word;
  logic               inst_vld;
  logic               jump_en;
  logic signed [11:0] jump_off;
  reg_addr_t          rd_addr, rr_addr, wr_addr;
  logic               wr_en;
  byte_t              wr_data, rd_data, rr_data;
  alu_op_t            alu_op;
  byte_t              alu_a, alu_b, alu_res;
  logic               alu_cin;
  sreg_t              alu_flags, flag_mask, flag_val, sreg;
  logic               io_wr, io_rd;
  io_addr_t           io_addr;
  byte_t              io_wdata, io_data;

  ////////////////////////////////////////
  // fetch and decode
  ////////////////////////////////////////

  avr_fetch #(.PAW(PAW)) u_fetch (
    .clk(clk), .rst(rst), .bp_rdy(bp_rdy),
    .jump_en(jump_en), .jump_off(jump_off), .bp_rdt(bp_rdt),
    .bp_vld(bp_vld), .bp_adr(bp_adr),
    .inst_word(inst_word), .inst_vld(inst_vld)
  );

  avr_decode #(.PAW(PAW)) u_decode (
    .inst_word(inst_word), .inst_vld(inst_vld),
    .rd_data(rd_data), .rr_data(rr_data),
    .alu_res(alu_res), .alu_flags(alu_flags),
    .io_data(io_data), .sreg(sreg),
    .rd_addr(rd_addr), .rr_addr(rr_addr), .wr_addr(wr_addr),
    .wr_en(wr_en), .wr_data(wr_data),
    .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_cin(alu_cin),
    .flag_mask(flag_mask), .flag_val(flag_val),
    .io_wr(io_wr), .io_rd(io_rd), .io_addr(io_addr), .io_wdata(io_wdata),
    .jump_en(jump_en), .jump_off(jump_off),
    .ctl_slp(ctl_slp), .ctl_brk(ctl_brk), .ctl_wdr(ctl_wdr)
  );

  ////////////////////////////////////////
  // execute and status
  ////////////////////////////////////////

  avr_regfile u_regfile (
    .clk(clk), .rd_addr(rd_addr), .rr_addr(rr_addr),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_data(rd_data), .rr_data(rr_data)
  );

  avr_alu u_alu (
    .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_cin(alu_cin),
    .alu_res(alu_res), .alu_flags(alu_flags)
  );

  avr_sreg_io u_sreg_io (
    .clk(clk), .rst(rst),
    .flag_mask(flag_mask), .flag_val(flag_val),
    .io_wr(io_wr), .io_rd(io_rd), .io_addr(io_addr),
    .io_wdata(io_wdata), .io_rdt(io_rdt),
    .sreg(sreg), .io_data(io_data),
    .io_wen(io_wen), .io_ren(io_ren), .io_adr(io_adr),
    .io_wdt(io_wdt), .io_msk(io_msk)
  );

endmodule

`default_nettype wire

//--- tb/avr_core_props.sv
// bus and control rules, bound into the core

`timescale 1ns/1ps
`default_nettype none

module avr_core_props (
  input wire logic       clk,
  input wire logic       rst,
  input wire logic       bp_vld,
  input wire logic       io_wen,
  input wire logic       io_ren,
  input wire logic [5:0] io_adr,
  input wire logic       ctl_slp,
  input wire logic       ctl_brk,
  input wire logic       ctl_wdr
);

  int fails = 0; // assertion failures so far

  a_rw_excl: assert property (@(posedge clk) disable iff (rst) !(io_wen && io_ren))
    else begin
      $error("io_wen and io_ren high together");
      fails++;
    end
  a_no_internal: assert property (@(posedge clk) disable iff (rst)
    (io_wen || io_ren) |-> (io_adr < 6'h38))
    else begin
      $error("bus strobe for an internal address");
      fails++;
    end
  a_one_pulse: assert property (@(posedge clk) disable iff (rst)
    $onehot0({ctl_slp, ctl_brk, ctl_wdr}))
    else begin
      $error("several control pulses at once");
      fails++;
    end
  a_rst_idle: assert property (@(posedge clk) rst |-> !bp_vld)
    else begin
      $error("program request during reset");
      fails++;
    end

endmodule

bind avr_core avr_core_props u_props (
  .clk(clk), .rst(rst), .bp_vld(bp_vld), .io_wen(io_wen), .io_ren(io_ren),
  .io_adr(io_adr), .ctl_slp(ctl_slp), .ctl_brk(ctl_brk), .ctl_wdr(ctl_wdr)
);

`default_nettype wire

//--- tb/avr_core_checker.sv
// event checker for the core testbench
// samples the i/o strobes and control pulses at each rising edge and
// compares them in order against the expected event list

`timescale 1ns/1ps
`default_nettype none

module avr_core_checker (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire logic       io_wen,
  input  wire logic       io_ren,
  input  wire logic [5:0] io_adr,
  input  wire logic [7:0] io_wdt,
  input  wire logic [7:0] io_msk,
  input  wire logic       ctl_slp,
  input  wire logic       ctl_brk,
  input  wire logic       ctl_wdr,
  output int              errors,
  output logic            done
);

  logic [7:0] exp_kind [64]; // W, R, S, B or D
  logic [5:0] exp_adr [64];
  logic [7:0] exp_dat [64];
  int         total = 0;
  int         next = 0;
  logic [7:0] kind;

  initial errors = 0;
  assign done = (next == total);

  task automatic add_expected(input logic [7:0] k, input logic [5:0] a,
                              input logic [7:0] d);
    exp_kind[total] = k;
    exp_adr[total]  = a;
    exp_dat[total]  = d;
    total++;
  endtask

  always @(posedge clk) begin
    if (!rst && (io_wen | io_ren | ctl_slp | ctl_brk | ctl_wdr)) begin
      kind = io_wen ? "W" : io_ren ? "R" : ctl_slp ? "S" : ctl_brk ? "B" : "D";
      if ((32'(io_wen) + 32'(io_ren) + 32'(ctl_slp) + 32'(ctl_brk) + 32'(ctl_wdr)) > 1) begin
        $display("more than one strobe or pulse in the same cycle");
        errors++;
      end
      if (next >= total) begin
        $display("%c event seen after the expected list ended", kind);
        errors++;
      end else begin
        if (kind != exp_kind[next]) begin
          $display("event %0d: expected a %c event, saw a %c event",
                   next, exp_kind[next], kind);
          errors++;
        end else if (kind == "W" || kind == "R") begin
          if (io_adr != exp_adr[next]) begin
            $display("[ERROR] io_adr expected %h got %h", exp_adr[next], io_adr);
            errors++;
          end
          if (kind == "W" && io_wdt != exp_dat[next]) begin
            $display("[ERROR] io_wdt expected %h got %h", exp_dat[next], io_wdt);
            errors++;
          end
          if (kind == "W" && io_msk != 8'hff) begin
            $display("[ERROR] io_msk expected ff got %h", io_msk);
            errors++;
          end
        end
        next++;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/avr_core_tb.sv
// testbench top for the 8-bit core
// loads program, i/o read data and expected events from the vector file,
// models a synchronous program memory with random stalls, prints the report

`timescale 1ns/1ps
`default_nettype none

module avr_core_tb;

  localparam int unsigned PAW = 11;

  logic           clk;
  logic           rst;
  logic           bp_vld;
  logic [PAW-1:0] bp_adr;
  logic [15:0]    bp_rdt;
  logic           bp_rdy;
  logic           io_wen, io_ren;
  logic [5:0]     io_adr;
  logic [7:0]     io_wdt, io_msk, io_rdt;
  logic           ctl_slp, ctl_brk, ctl_wdr;

  logic [15:0]    prog [2**PAW]; // program image
  logic [7:0]     io_mem [64];   // io_rdt per i/o address
  logic           cap_vld;       // a request was captured
  logic [PAW-1:0] cap_adr;
  logic [31:0]    lcg_state = 32'h98052ffc;
  int             timeouts = 0;
  int             file_errors = 0;
  int             chk_errors;
  logic           chk_done;

  avr_core #(.PAW(PAW)) dut (
    .clk(clk), .rst(rst),
    .bp_vld(bp_vld), .bp_adr(bp_adr), .bp_rdt(bp_rdt), .bp_rdy(bp_rdy),
    .io_wen(io_wen), .io_ren(io_ren), .io_adr(io_adr),
    .io_wdt(io_wdt), .io_msk(io_msk), .io_rdt(io_rdt),
    .ctl_slp(ctl_slp), .ctl_brk(ctl_brk), .ctl_wdr(ctl_wdr)
  );

  avr_core_checker chk (
    .clk(clk), .rst(rst), .io_wen(io_wen), .io_ren(io_ren), .io_adr(io_adr),
    .io_wdt(io_wdt), .io_msk(io_msk), .ctl_slp(ctl_slp), .ctl_brk(ctl_brk),
    .ctl_wdr(ctl_wdr), .errors(chk_errors), .done(chk_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // i/o read data is a plain lookup on the current address
  assign io_rdt = io_mem[io_adr];

  ////////////////////////////////////////
  // program memory model
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      cap_vld <= 1'b0;
    end else begin
      cap_vld <= bp_vld;
      cap_adr <= bp_adr;
    end
  end

  always @(negedge clk) begin
    if (cap_vld) begin
      lcg_state = next_rand(lcg_state);
      bp_rdt <= prog[cap_adr];
      bp_rdy <= (lcg_state[31:30] != 2'b00); // stall about 1 in 4
    end else begin
      bp_rdy <= 1'b0;
    end
  end

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  kind;
    logic [15:0] a;
    logic [15:0] d;
    for (int i = 0; i < 2**PAW; i++) prog[i] = {5'b0, i[10:0]};
    for (int i = 0; i < 64; i++) io_mem[i] = 8'(i) ^ 8'ha5;
    fd = $fopen("tb/avr_core_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file");
      file_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n < 2) continue;
      case (line.getc(0))
        "P": if ($sscanf(line, "P %h %h", a, d) == 2) prog[a[PAW-1:0]] = d;
        "R": if ($sscanf(line, "R %h %h", a, d) == 2) io_mem[a[5:0]] = d[7:0];
        "E": if ($sscanf(line, "E %c %h %h", kind, a, d) == 3)
          chk.add_expected(kind, a[5:0], d[7:0]);
        default: ; // comment or blank
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    int cycles;
    int assert_fails;
    rst    = 1'b1;
    bp_rdt = '0;
    bp_rdy = 1'b0;
    load_vectors();
    repeat (5) @(posedge clk);
    @(negedge clk) rst = 1'b0;
    cycles = 0;
    while (!chk_done && cycles < 2000) begin
      @(posedge clk);
      cycles++;
    end
    if (!chk_done) begin
      $display("timeout: expected events still pending");
      timeouts++;
    end
    repeat (20) @(posedge clk); // stray events after the list
    assert_fails = dut.u_props.fails;
    $display("checks done: %0d mismatches, %0d assert fails, %0d timeouts, %0d file errors",
             chk_errors, assert_fails, timeouts, file_errors);
    if (chk_errors == 0 && assert_fails == 0 && timeouts == 0 && file_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/avr_core_vectors.txt
# P word_addr word | R io_addr rdata | E kind(W R S B D) io_addr data
# all values hex, E lines in expected order
P 00 E30C
P 01 B905
P 02 EC15
P 03 0F01
P 04 1F01
P 05 B906
P 06 B72F
P 07 B927
P 08 5D10
P 09 4010
P 0a 3F14
P 0b B73F
P 0c B938
P 0d EA45
P 0e 704F
P 0f 6840
P 10 9542
P 11 9540
P 12 9546
P 13 9547
P 14 B949
P 15 B15A
P 16 9551
P 17 9553
P 18 9555
P 19 955A
P 1a B95B
P 1b BF3F
P 1c 9478
P 1d 9498
P 1e B76F
P 1f B96C
P 20 9588
P 21 C002
P 22 B96D
P 23 9598
P 24 9598
P 25 95A8
P 26 2E01
P 27 1A00
P 28 1400
P 29 0A00
P 2a 0400
P 2b 2206
P 2c 2A01
P 2d B61F
P 2e B81E
P 2f B80F
P 30 CFFF
R 0a 6B
E W 05 3C
E W 06 C7
E W 07 14
E W 08 02
E W 09 A9
E R 0a 00
E W 0b CA
E W 0c 80
E S 00 00
E B 00 00
E D 00 00
E W 0e B5
E W 0f F4

//--- verilog.f
design/avr_pkg.sv
design/avr_fetch.sv
design/avr_decode.sv
design/avr_regfile.sv
design/avr_alu.sv
design/avr_sreg_io.sv
design/avr_core.sv
tb/avr_core_props.sv
tb/avr_core_checker.sv
tb/avr_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module avr_core_tb \
  -o avr_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/avr_core_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
exit 0
